// ==== logic/aggregation_bank.sv ====
// Aggregation bank: sums edge streams element-wise and sends the result to the RS or the SRAM.
`timescale 1ns/1ps

module aggregation_bank import gnn_bank_pkg::*; #(
    parameter int max_fv_num = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  edge_pkt_t   edge_pkt,
    input  logic        req_grant,
    output rs_pkt_t     rs_pkt,
    output outbuf_pkt_t outbuf_pkt
);

    localparam int cnt_w = $clog2(max_fv_num);

    localparam logic [2:0] idle        = 3'd0;
    localparam logic [2:0] stream_in   = 3'd1;
    localparam logic [2:0] complete    = 3'd2;
    localparam logic [2:0] out_rs      = 3'd3;
    localparam logic [2:0] out_fv_wait = 3'd4;
    localparam logic [2:0] out_fv      = 3'd5;

    logic [max_fv_num-1:0][fv_size-1:0] buffer; // Running sums for the current node.
    logic [cnt_w-1:0]                   cnt;    // Element index, steps by two.
    logic [node_id_size-1:0]            cur_node;
    logic [2:0]                         state;
    logic                               take_beat;
    logic                               last_pair;

    // A beat is summed on the sos in IDLE and on every cycle of STREAM_IN.
    assign take_beat = (state == idle && edge_pkt.sos) || state == stream_in;
    assign last_pair = (cnt == cnt_w'(max_fv_num - 2));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= idle;
            cnt        <= '0;
            cur_node   <= '0;
            buffer     <= '0;
            rs_pkt     <= '0;
            outbuf_pkt <= '0;
        end else begin
            if (take_beat) begin
                buffer[cnt]   <= buffer[cnt] + edge_pkt.fv_data[0];
                buffer[cnt+1] <= buffer[cnt+1] + edge_pkt.fv_data[1];
                cnt           <= edge_pkt.eos ? '0 : cnt + cnt_w'(2); // Rewind at end of stream.
            end

            case (state)
                idle: begin
                    rs_pkt.sos             <= 1'b0;
                    rs_pkt.eos             <= 1'b0;
                    outbuf_pkt.req         <= 1'b0;
                    outbuf_pkt.grant_valid <= 1'b0;
                    outbuf_pkt.sos         <= 1'b0;
                    outbuf_pkt.eos         <= 1'b0;
                    if (edge_pkt.sos) begin
                        cur_node <= edge_pkt.node_id;
                        state    <= edge_pkt.eos ? complete : stream_in;
                    end
                end

                stream_in: begin
                    if (edge_pkt.eos) begin
                        state <= complete;
                    end
                end

                // Mode flags from the former are valid in this cycle only.
                complete: begin
                    if (edge_pkt.done_aggr) begin
                        rs_pkt.sos     <= 1'b1; // First RS beat goes out now.
                        rs_pkt.eos     <= 1'b0;
                        rs_pkt.node_id <= cur_node;
                        rs_pkt.fv_data <= buffer[cnt +: 2];
                        cnt            <= cnt + cnt_w'(2);
                        state          <= out_rs;
                    end else if (edge_pkt.wb_en) begin
                        outbuf_pkt.req <= 1'b1; // Ask for the SRAM port.
                        state          <= out_fv_wait;
                    end else begin
                        state <= idle; // Accumulate: sums stay in the buffer.
                    end
                end

                out_rs: begin
                    rs_pkt.sos     <= 1'b0;
                    rs_pkt.eos     <= last_pair;
                    rs_pkt.fv_data <= buffer[cnt +: 2];
                    if (last_pair) begin
                        buffer <= '0;
                        cnt    <= '0;
                        state  <= idle;
                    end else begin
                        cnt <= cnt + cnt_w'(2);
                    end
                end

                out_fv_wait: begin
                    if (req_grant) begin
                        outbuf_pkt.req         <= 1'b0; // Request ends as the stream starts.
                        outbuf_pkt.grant_valid <= 1'b1;
                        outbuf_pkt.sos         <= 1'b1;
                        outbuf_pkt.eos         <= 1'b0;
                        outbuf_pkt.node_id     <= cur_node;
                        outbuf_pkt.data        <= buffer[cnt +: 2];
                        cnt                    <= cnt + cnt_w'(2);
                        state                  <= out_fv;
                    end
                end

                out_fv: begin
                    outbuf_pkt.sos  <= 1'b0;
                    outbuf_pkt.eos  <= last_pair;
                    outbuf_pkt.data <= buffer[cnt +: 2];
                    if (last_pair) begin
                        buffer <= '0;
                        cnt    <= '0;
                        state  <= idle;
                    end else begin
                        cnt <= cnt + cnt_w'(2);
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== logic/edge_stream_former.sv ====
// Input side of the bank: registers valid/last beats into marked edge packets with mode flags.
`timescale 1ns/1ps

module edge_stream_former import gnn_bank_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fv_valid,
    input  logic                    fv_last,
    input  logic                    mode_done,
    input  logic                    mode_wb,
    input  logic [node_id_size-1:0] node_id,
    input  fv_pair_t                fv_data,
    output edge_pkt_t               edge_pkt
);

    logic                    in_stream;   // A stream has started and not yet ended.
    logic                    first_beat;
    logic                    mode_done_q; // Mode levels seen on the first beat.
    logic                    mode_wb_q;
    logic                    sos_q;
    logic                    eos_q;
    logic                    done_q;
    logic                    wb_q;
    logic [node_id_size-1:0] node_q;
    fv_pair_t                data_q;

    assign first_beat = fv_valid && !in_stream;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            in_stream   <= 1'b0;
            mode_done_q <= 1'b0;
            mode_wb_q   <= 1'b0;
            sos_q       <= 1'b0;
            eos_q       <= 1'b0;
            done_q      <= 1'b0;
            wb_q        <= 1'b0;
        end else begin
            if (fv_valid) begin
                in_stream <= !fv_last; // Closes on the last beat.
            end
            if (first_beat) begin
                mode_done_q <= mode_done;
                mode_wb_q   <= mode_wb;
            end
            sos_q <= first_beat;
            eos_q <= fv_valid && fv_last;
            // Flags show for one cycle right after eos, when the bank is in COMPLETE.
            done_q <= eos_q && mode_done_q;
            wb_q   <= eos_q && mode_wb_q && !mode_done_q; // Done wins over write back.
        end
    end

    always_ff @(posedge clk) begin
        if (fv_valid) begin
            node_q <= node_id;
            data_q <= fv_data;
        end
    end

    assign edge_pkt = '{
        sos:       sos_q,
        eos:       eos_q,
        done_aggr: done_q,
        wb_en:     wb_q,
        node_id:   node_q,
        fv_data:   data_q
    };

endmodule

// ==== logic/gnn_bank_pkg.sv ====
// Shared widths and packed stream types for the aggregation bank RTL and its testbench.
package gnn_bank_pkg;

    // One feature element. Sums wrap modulo 2**fv_size.
    localparam int fv_size = 16;

    localparam int node_id_size = 8; // Width of a node id.

    // One beat of feature data; element 0 sits in the low half.
    typedef logic [1:0][fv_size-1:0] fv_pair_t;

    // Edge packet from the stream former into the bank.
    typedef struct packed {
        logic                    sos;       // First beat of the stream.
        logic                    eos;       // Last beat of the stream.
        logic                    done_aggr; // Send sums to the RS after this stream.
        logic                    wb_en;     // Write sums back to the output SRAM.
        logic [node_id_size-1:0] node_id;
        fv_pair_t                fv_data;
    } edge_pkt_t;

    // Result stream towards the reservation station.
    typedef struct packed {
        logic                    sos;
        logic                    eos;
        logic [node_id_size-1:0] node_id;
        fv_pair_t                fv_data;
    } rs_pkt_t;

    // Request and write-back stream from the bank to the SRAM write port.
    typedef struct packed {
        logic                    req;         // Held while waiting for the port.
        logic                    grant_valid; // High on every beat of a granted stream.
        logic                    sos;
        logic                    eos;
        logic [node_id_size-1:0] node_id;
        fv_pair_t                data;
    } outbuf_pkt_t;

endpackage

// ==== logic/gnn_bank_top.sv ====
// Top level of one aggregation bank: input former, bank and SRAM write port wired together.
`timescale 1ns/1ps

module gnn_bank_top import gnn_bank_pkg::*; #(
    parameter int max_fv_num = 8 // Feature elements per node, even and at least 4.
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         fv_valid,
    input  logic                                         fv_last,
    input  logic                                         mode_done,
    input  logic                                         mode_wb,
    input  logic [node_id_size-1:0]                      node_id,
    input  fv_pair_t                                     fv_data,
    input  logic                                         sram_busy,
    output rs_pkt_t                                      rs_pkt,
    output logic                                         sram_we,
    output logic [node_id_size+$clog2(max_fv_num/2)-1:0] sram_addr,
    output fv_pair_t                                     sram_wdata
);

    edge_pkt_t   edge_pkt;
    outbuf_pkt_t outbuf_pkt;
    logic        req_grant;

    edge_stream_former u_former (
        .clk       (clk),
        .reset     (reset),
        .fv_valid  (fv_valid),
        .fv_last   (fv_last),
        .mode_done (mode_done),
        .mode_wb   (mode_wb),
        .node_id   (node_id),
        .fv_data   (fv_data),
        .edge_pkt  (edge_pkt)
    );

    aggregation_bank #(
        .max_fv_num (max_fv_num)
    ) u_bank (
        .clk        (clk),
        .reset      (reset),
        .edge_pkt   (edge_pkt),
        .req_grant  (req_grant),
        .rs_pkt     (rs_pkt),
        .outbuf_pkt (outbuf_pkt)
    );

    outbuf_write_port #(
        .max_fv_num (max_fv_num)
    ) u_write_port (
        .clk        (clk),
        .reset      (reset),
        .sram_busy  (sram_busy),
        .outbuf_pkt (outbuf_pkt),
        .req_grant  (req_grant),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata)
    );

endmodule

// ==== logic/outbuf_write_port.sv ====
// Output SRAM port: grants the bank's request and turns its write-back stream into SRAM writes.
`timescale 1ns/1ps

module outbuf_write_port import gnn_bank_pkg::*; #(
    parameter int max_fv_num = 8
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                sram_busy,
    input  outbuf_pkt_t                                         outbuf_pkt,
    output logic                                                req_grant,
    output logic                                                sram_we,
    output logic [node_id_size+$clog2(max_fv_num/2)-1:0]        sram_addr,
    output fv_pair_t                                            sram_wdata
);

    localparam int idx_w  = $clog2(max_fv_num / 2);
    localparam int addr_w = node_id_size + idx_w;

    logic [node_id_size-1:0] node_q;    // Node of the stream in flight.
    logic [idx_w-1:0]        idx_q;     // Index of the next beat.
    logic [node_id_size-1:0] beat_node;
    logic [idx_w-1:0]        beat_idx;
    logic [addr_w-1:0]       beat_addr;

    // The sos beat carries its own node and restarts the index.
    assign beat_node = outbuf_pkt.sos ? outbuf_pkt.node_id : node_q;
    assign beat_idx  = outbuf_pkt.sos ? '0 : idx_q;
    assign beat_addr = addr_w'(beat_node) * addr_w'(max_fv_num / 2) + addr_w'(beat_idx);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            req_grant <= 1'b0;
            sram_we   <= 1'b0;
            node_q    <= '0;
            idx_q     <= '0;
        end else begin
            if (req_grant) begin
                if (outbuf_pkt.eos) begin
                    req_grant <= 1'b0; // Release once the last beat has passed.
                end
            end else if (outbuf_pkt.req && !sram_busy) begin
                req_grant <= 1'b1;
            end

            sram_we <= outbuf_pkt.grant_valid; // One write per stream beat.
            if (outbuf_pkt.grant_valid) begin
                node_q <= beat_node;
                idx_q  <= beat_idx + idx_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (outbuf_pkt.grant_valid) begin
            sram_addr  <= beat_addr;
            sram_wdata <= outbuf_pkt.data;
        end
    end

endmodule

// ==== project.f ====
logic/gnn_bank_pkg.sv
logic/edge_stream_former.sv
logic/aggregation_bank.sv
logic/outbuf_write_port.sv
logic/gnn_bank_top.sv
sim/tb_gnn_bank.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exits non-zero on failure.
set -u

cd "$(dirname "$0")" || exit 1

log_file="sim.log"

rm -rf obj_dir
if ! verilator --binary --timing -Wno-fatal -f project.f \
        --top-module tb_gnn_bank -o tb_gnn_bank; then
    echo "RESULT: FAIL (Verilator build error)"
    exit 1
fi

./obj_dir/tb_gnn_bank > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Simulation failed" "$log_file"; then
    echo "RESULT: FAIL"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "RESULT: FAIL (simulator exit status $run_status)"
    exit 1
fi

echo "RESULT: PASS"
exit 0

// ==== sim/tb_gnn_bank.sv ====
// Self-checking testbench for gnn_bank_top; drives random edge streams and checks against a model.
`timescale 1ns/1ps

module tb_gnn_bank import gnn_bank_pkg::*; ();

    localparam int max_fv_num     = 8;
    localparam int beats          = max_fv_num / 2;
    localparam int addr_w         = node_id_size + $clog2(beats);
    localparam int num_rounds     = 24;
    localparam int timeout_cycles = 200;

    logic                    clk;
    logic                    reset;
    logic                    fv_valid;
    logic                    fv_last;
    logic                    mode_done;
    logic                    mode_wb;
    logic [node_id_size-1:0] node_id;
    fv_pair_t                fv_data;
    logic                    sram_busy;
    rs_pkt_t                 rs_pkt;
    logic                    sram_we;
    logic [addr_w-1:0]       sram_addr;
    fv_pair_t                sram_wdata;

    logic [fv_size-1:0]      model [max_fv_num]; // Expected running sums.
    logic                    grant_q;
    logic                    busy_q;

    gnn_bank_top #(
        .max_fv_num (max_fv_num)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .fv_valid   (fv_valid),
        .fv_last    (fv_last),
        .mode_done  (mode_done),
        .mode_wb    (mode_wb),
        .node_id    (node_id),
        .fv_data    (fv_data),
        .sram_busy  (sram_busy),
        .rs_pkt     (rs_pkt),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata)
    );

    always #20 clk = ~clk; // 40 ns period.

    task automatic report_mismatch(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_hang(input string msg);
        $display("Timeout: %s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped on a timeout");
    endtask

    // One clock edge; the SRAM busy level changes at random.
    task automatic step_clock();
        @(posedge clk);
        sram_busy <= ($urandom % 2) == 1;
    endtask

    task automatic idle_gap(input int n);
        repeat (n) step_clock();
    endtask

    task automatic clear_model();
        for (int i = 0; i < max_fv_num; i++) begin
            model[i] = '0;
        end
    endtask

    // Sends one edge stream and adds it into the model.
    task automatic drive_stream(input logic [node_id_size-1:0] node, input logic md,
                                input logic mw);
        fv_pair_t pair;
        for (int b = 0; b < beats; b++) begin
            pair[0] = fv_size'($urandom_range(16'h4000, 16'hffff)); // Large values force wraps.
            pair[1] = fv_size'($urandom_range(16'h4000, 16'hffff));
            model[2*b]   = model[2*b] + pair[0];
            model[2*b+1] = model[2*b+1] + pair[1];
            fv_valid  <= 1'b1;
            fv_last   <= (b == beats - 1);
            node_id   <= node;
            fv_data   <= pair;
            mode_done <= md && (b == 0); // Mode levels count on the first beat only.
            mode_wb   <= mw && (b == 0);
            step_clock();
            assert (!rs_pkt.sos && !sram_we)
                else report_mismatch("output active while an edge stream comes in");
        end
        fv_valid  <= 1'b0;
        fv_last   <= 1'b0;
        mode_done <= 1'b0;
        mode_wb   <= 1'b0;
    endtask

    // Called on the edge that samples fv_last.
    task automatic check_rs_stream(input logic [node_id_size-1:0] node);
        int       cycles;
        fv_pair_t exp_pair;
        cycles = 0;
        do begin
            step_clock();
            cycles++;
            if (cycles > timeout_cycles) begin
                report_hang("no RS stream started after the last input beat");
            end
        end while (!rs_pkt.sos);
        assert (cycles == 3)
            else report_mismatch($sformatf("RS sos %0d cycles after fv_last, expected 3", cycles));
        for (int b = 0; b < beats; b++) begin
            if (b > 0) begin
                step_clock();
            end
            exp_pair[0] = model[2*b];
            exp_pair[1] = model[2*b+1];
            assert (rs_pkt.sos == (b == 0) && rs_pkt.eos == (b == beats - 1))
                else report_mismatch($sformatf("RS beat %0d has wrong sos/eos", b));
            assert (rs_pkt.node_id == node)
                else report_mismatch($sformatf("RS node %0d, expected %0d", rs_pkt.node_id, node));
            assert (rs_pkt.fv_data == exp_pair)
                else report_mismatch($sformatf("RS beat %0d data %h, expected %h",
                                               b, rs_pkt.fv_data, exp_pair));
        end
        step_clock();
        assert (!rs_pkt.sos && !rs_pkt.eos) else report_mismatch("RS stream longer than expected");
        clear_model();
    endtask

    task automatic check_write_back(input logic [node_id_size-1:0] node);
        int                cycles;
        fv_pair_t          exp_pair;
        logic [addr_w-1:0] exp_addr;
        cycles = 0;
        do begin
            step_clock();
            cycles++;
            if (cycles > timeout_cycles) begin
                report_hang("no SRAM write came after a write-back stream");
            end
        end while (!sram_we);
        for (int b = 0; b < beats; b++) begin
            if (b > 0) begin
                step_clock();
            end
            exp_pair[0] = model[2*b];
            exp_pair[1] = model[2*b+1];
            exp_addr    = addr_w'(node * beats + b); // Row of the node, then the beat.
            assert (sram_we) else report_mismatch($sformatf("SRAM write %0d missing", b));
            assert (sram_addr == exp_addr)
                else report_mismatch($sformatf("SRAM address %h, expected %h", sram_addr, exp_addr));
            assert (sram_wdata == exp_pair)
                else report_mismatch($sformatf("SRAM write %0d data %h, expected %h",
                                               b, sram_wdata, exp_pair));
        end
        step_clock();
        assert (!sram_we) else report_mismatch("more SRAM writes than beats per node");
        clear_model();
    endtask

    // A new grant must follow an edge where sram_busy was low.
    always @(posedge clk) begin
        if (!reset) begin
            grant_q <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            if (uut.req_grant && !grant_q) begin
                assert (!busy_q) else report_mismatch("SRAM port granted while sram_busy was high");
            end
            grant_q <= uut.req_grant;
            busy_q  <= sram_busy;
        end
    end

    initial begin
        logic [node_id_size-1:0] node;
        int                      n_streams;
        logic                    use_done;
        logic                    is_last;
        void'($urandom(12404));
        clk       = 1'b0;
        reset     = 1'b0;
        fv_valid  = 1'b0;
        fv_last   = 1'b0;
        mode_done = 1'b0;
        mode_wb   = 1'b0;
        node_id   = '0;
        fv_data   = '0;
        sram_busy = 1'b0;
        clear_model();

        for (int c = 0; c < 8; c++) begin
            step_clock();
            if (c > 0) begin // Outputs settle from the first edge on.
                assert (!rs_pkt.sos && !rs_pkt.eos && !sram_we)
                    else report_mismatch("output active during reset");
            end
        end
        reset <= 1'b1;
        for (int c = 0; c < 3; c++) begin
            step_clock();
            assert (!rs_pkt.sos && !rs_pkt.eos && !sram_we)
                else report_mismatch("output active right after reset");
        end

        for (int r = 0; r < num_rounds; r++) begin
            node      = node_id_size'($urandom_range(0, 255));
            n_streams = $urandom_range(1, 4);
            use_done  = ($urandom % 2) == 0;
            for (int s = 0; s < n_streams; s++) begin
                is_last = (s == n_streams - 1);
                drive_stream(node, is_last && use_done, is_last && !use_done);
                if (!is_last) begin
                    idle_gap($urandom_range(1, 3));
                end
            end
            if (use_done) begin
                check_rs_stream(node);
            end else begin
                check_write_back(node);
            end
            idle_gap(2);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
